//--- mailbox_pkg.sv
package mailbox_pkg;

  // Port and datapath sizing
  localparam int N_PORTS = 5;
  localparam int PORT_W  = 3;
  localparam int ADDR_W  = 16;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = 4;

  localparam int FIFO_DEPTH = 4;

  // Hop count saturates here
  localparam logic [3:0] HOPS_MAX = 4'd15;

  // Prio writes in a row before best-effort is forced through
  localparam int LAT_LIMIT = 3;

  // Cluster byte codes, taken from awaddr[15:8]
  localparam logic [7:0] CLUSTER_HP    = 8'h00;
  localparam logic [7:0] CLUSTER_BCAST = 8'hFF;

  // Index i holds the cluster reached through switch output i
  localparam logic [3:0][7:0] CHILD_CLUSTER_ID = {8'h04, 8'h03, 8'h02, 8'h01};

  typedef enum logic [PORT_W-1:0] {
    PORT_SW0 = 3'd0,
    PORT_SW1 = 3'd1,
    PORT_SW2 = 3'd2,
    PORT_SW3 = 3'd3,
    PORT_HP  = 3'd4
  } port_e;

  typedef struct packed {
    logic       prio;
    logic       eop;
    logic [3:0] hops;
    logic       parity;
  } mailbox_tag_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    mailbox_tag_t      tag;
  } flit_t;

  // Even parity over data and every tag field but parity itself
  function automatic logic tag_parity(
    input logic [DATA_W-1:0] data,
    input mailbox_tag_t      tag
  );
    return ^{data, tag.prio, tag.eop, tag.hops};
  endfunction

endpackage

//--- mailbox_ingress.sv
`timescale 1ns/1ps

module mailbox_ingress (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             awvalid_i,
  output logic                             awready_o,
  input  logic [mailbox_pkg::ADDR_W-1:0]   awaddr_i,
  input  logic                             wvalid_i,
  output logic                             wready_o,
  input  logic [mailbox_pkg::DATA_W-1:0]   wdata_i,
  input  logic [mailbox_pkg::STRB_W-1:0]   wstrb_i,
  input  mailbox_pkg::mailbox_tag_t        tag_i,
  output logic                             bvalid_o,
  input  logic                             bready_i,

  output logic                             req_o,
  output logic [mailbox_pkg::N_PORTS-1:0]  tgt_o,
  output mailbox_pkg::flit_t               flit_o,
  input  logic                             grant_i
);

  logic                      resp_pending;
  logic [7:0]                cluster;
  mailbox_pkg::mailbox_tag_t tag_upd;

  // A source waits for its write response before the next request
  assign req_o = awvalid_i && wvalid_i && !resp_pending;

  // Grant is the acceptance, both channels take the beat together
  assign awready_o = grant_i;
  assign wready_o  = grant_i;
  assign bvalid_o  = resp_pending;

  assign cluster = awaddr_i[mailbox_pkg::ADDR_W-1 -: 8];

  always_comb begin
    tgt_o = '0;
    if (cluster == mailbox_pkg::CLUSTER_BCAST) begin
      tgt_o = '1;
    end else if (cluster == mailbox_pkg::CLUSTER_HP) begin
      tgt_o[mailbox_pkg::PORT_HP] = 1'b1;
    end else begin
      for (int i = int'(mailbox_pkg::PORT_SW0); i <= int'(mailbox_pkg::PORT_SW3); i++) begin
        if (cluster == mailbox_pkg::CHILD_CLUSTER_ID[i]) begin
          tgt_o[i] = 1'b1;
        end
      end
    end
  end

  // One more hop through the root, then reseal the parity
  always_comb begin
    tag_upd = tag_i;
    if (tag_i.hops != mailbox_pkg::HOPS_MAX) begin
      tag_upd.hops = tag_i.hops + 4'd1;
    end
    tag_upd.parity = mailbox_pkg::tag_parity(wdata_i, tag_upd);
  end

  assign flit_o = '{addr: awaddr_i, data: wdata_i, strb: wstrb_i, tag: tag_upd};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_pending <= 1'b0;
    end else if (grant_i) begin
      resp_pending <= 1'b1;
    end else if (resp_pending && bready_i) begin
      resp_pending <= 1'b0;
    end
  end

  // Crossbar must only grant a source presenting a full request
  a_ready_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    awready_o |-> (awvalid_i && wvalid_i)
  );

endmodule

//--- mailbox_out_arbiter.sv
`timescale 1ns/1ps

module mailbox_out_arbiter (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic [mailbox_pkg::N_PORTS-1:0]  req_i,
  input  logic [mailbox_pkg::N_PORTS-1:0]  prio_i,
  input  logic [3:0]                       hops_i [mailbox_pkg::N_PORTS],
  input  logic                             wr_i,
  input  logic                             wr_prio_i,

  output logic [mailbox_pkg::PORT_W-1:0]   sel_o,
  output logic                             sel_valid_o
);

  localparam int CNT_W = $clog2(mailbox_pkg::LAT_LIMIT + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(mailbox_pkg::LAT_LIMIT);
  localparam logic [mailbox_pkg::PORT_W-1:0] RR_LAST =
    mailbox_pkg::PORT_W'(mailbox_pkg::N_PORTS - 1);

  logic [mailbox_pkg::PORT_W-1:0] rr_q;
  logic [CNT_W-1:0]               lat_q;

  always_comb begin
    logic [mailbox_pkg::N_PORTS-1:0] be_req;
    logic [mailbox_pkg::N_PORTS-1:0] pr_req;
    logic [mailbox_pkg::N_PORTS-1:0] cand;
    logic [3:0]                      best;
    logic                            found;
    int                              idx;

    be_req = req_i & ~prio_i;
    pr_req = req_i & prio_i;

    // Starvation guard first, otherwise prio class wins
    if ((lat_q == CNT_MAX) && (|be_req)) begin
      cand = be_req;
    end else if (|pr_req) begin
      cand = pr_req;
    end else begin
      cand = req_i;
    end

    found = 1'b0;
    best  = '0;
    sel_o = '0;
    // Scan from the pointer, strictly larger hops displaces the earlier pick
    for (int k = 0; k < mailbox_pkg::N_PORTS; k++) begin
      idx = int'(rr_q) + k;
      if (idx >= mailbox_pkg::N_PORTS) begin
        idx = idx - mailbox_pkg::N_PORTS;
      end
      if (cand[idx] && (!found || (hops_i[idx] > best))) begin
        found = 1'b1;
        best  = hops_i[idx];
        sel_o = mailbox_pkg::PORT_W'(idx);
      end
    end
    sel_valid_o = found;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_q  <= '0;
      lat_q <= '0;
    end else if (wr_i) begin
      rr_q <= (rr_q == RR_LAST) ? '0 : rr_q + 1'b1;
      if (!wr_prio_i) begin
        lat_q <= '0;
      end else if (lat_q != CNT_MAX) begin
        lat_q <= lat_q + 1'b1;
      end
    end
  end

  a_sel_requests: assert property (
    @(posedge clk) disable iff (!rst_n)
    sel_valid_o |-> req_i[sel_o]
  );

endmodule

//--- mailbox_crossbar.sv
`timescale 1ns/1ps

module mailbox_crossbar (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             req_i     [mailbox_pkg::N_PORTS],
  input  logic [mailbox_pkg::N_PORTS-1:0]  tgt_i     [mailbox_pkg::N_PORTS],
  input  mailbox_pkg::flit_t               flit_i    [mailbox_pkg::N_PORTS],
  input  logic                             full_i    [mailbox_pkg::N_PORTS],

  output logic                             grant_o   [mailbox_pkg::N_PORTS],
  output logic                             wr_en_o   [mailbox_pkg::N_PORTS],
  output mailbox_pkg::flit_t               wr_flit_o [mailbox_pkg::N_PORTS]
);

  logic [mailbox_pkg::N_PORTS-1:0] arb_req   [mailbox_pkg::N_PORTS];
  logic [mailbox_pkg::N_PORTS-1:0] src_prio;
  logic [3:0]                      src_hops  [mailbox_pkg::N_PORTS];
  logic [mailbox_pkg::PORT_W-1:0]  sel       [mailbox_pkg::N_PORTS];
  logic                            sel_valid [mailbox_pkg::N_PORTS];
  logic [mailbox_pkg::N_PORTS-1:0] out_gnt   [mailbox_pkg::N_PORTS];

  // Per-output request vectors, a full queue drops out of arbitration
  always_comb begin
    for (int i = 0; i < mailbox_pkg::N_PORTS; i++) begin
      src_prio[i] = flit_i[i].tag.prio;
      src_hops[i] = flit_i[i].tag.hops;
    end
    for (int o = 0; o < mailbox_pkg::N_PORTS; o++) begin
      for (int i = 0; i < mailbox_pkg::N_PORTS; i++) begin
        arb_req[o][i] = req_i[i] && tgt_i[i][o] && !full_i[o];
      end
    end
  end

  for (genvar o = 0; o < mailbox_pkg::N_PORTS; o++) begin : g_arb
    mailbox_out_arbiter i_arb (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_i       (arb_req[o]),
      .prio_i      (src_prio),
      .hops_i      (src_hops),
      .wr_i        (wr_en_o[o]),
      .wr_prio_i   (wr_flit_o[o].tag.prio),
      .sel_o       (sel[o]),
      .sel_valid_o (sel_valid[o])
    );
  end

  // Broadcasts go only when every targeted arbiter agrees this cycle
  always_comb begin
    logic ok;

    for (int i = 0; i < mailbox_pkg::N_PORTS; i++) begin
      ok = req_i[i] && (|tgt_i[i]);
      for (int o = 0; o < mailbox_pkg::N_PORTS; o++) begin
        if (tgt_i[i][o] && !(sel_valid[o] && (int'(sel[o]) == i))) begin
          ok = 1'b0;
        end
      end
      grant_o[i] = ok;
    end
  end

  always_comb begin
    for (int o = 0; o < mailbox_pkg::N_PORTS; o++) begin
      for (int i = 0; i < mailbox_pkg::N_PORTS; i++) begin
        out_gnt[o][i] = grant_o[i] && tgt_i[i][o];
      end
      wr_en_o[o]   = |out_gnt[o];
      wr_flit_o[o] = flit_i[sel[o]];
    end
  end

  for (genvar o = 0; o < mailbox_pkg::N_PORTS; o++) begin : g_chk
    a_one_grant_per_out: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(out_gnt[o])
    );
  end

endmodule

//--- mailbox_egress_queue.sv
`timescale 1ns/1ps

module mailbox_egress_queue (
  input  logic                             clk,
  input  logic                             rst_n,

  input  logic                             wr_en_i,
  input  mailbox_pkg::flit_t               wr_flit_i,
  output logic                             full_o,

  output logic                             m_awvalid_o,
  input  logic                             m_awready_i,
  output logic [mailbox_pkg::ADDR_W-1:0]   m_awaddr_o,
  output logic                             m_wvalid_o,
  input  logic                             m_wready_i,
  output logic [mailbox_pkg::DATA_W-1:0]   m_wdata_o,
  output logic [mailbox_pkg::STRB_W-1:0]   m_wstrb_o,
  output mailbox_pkg::mailbox_tag_t        m_tag_o
);

  localparam int PTR_W = $clog2(mailbox_pkg::FIFO_DEPTH);
  localparam logic [PTR_W:0] CNT_FULL = (PTR_W + 1)'(mailbox_pkg::FIFO_DEPTH);

  mailbox_pkg::flit_t mem [mailbox_pkg::FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     count;
  logic               empty;
  logic               pop;

  assign empty  = (count == '0);
  assign full_o = (count == CNT_FULL);

  // Both channels must take the head together
  assign pop = !empty && m_awready_i && m_wready_i;

  assign m_awvalid_o = !empty;
  assign m_wvalid_o  = !empty;
  assign m_awaddr_o  = mem[rd_ptr].addr;
  assign m_wdata_o   = mem[rd_ptr].data;
  assign m_wstrb_o   = mem[rd_ptr].strb;
  assign m_tag_o     = mem[rd_ptr].tag;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_ptr] <= wr_flit_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en_i |-> !full_o
  );

endmodule

//--- mailbox_center.sv
`timescale 1ns/1ps

module mailbox_center (
  input  logic                             clk,
  input  logic                             rst_n,

  // Ingress, index 4 is the HP port
  input  logic                             sw_awvalid_i [mailbox_pkg::N_PORTS],
  output logic                             sw_awready_o [mailbox_pkg::N_PORTS],
  input  logic [mailbox_pkg::ADDR_W-1:0]   sw_awaddr_i  [mailbox_pkg::N_PORTS],
  input  logic                             sw_wvalid_i  [mailbox_pkg::N_PORTS],
  output logic                             sw_wready_o  [mailbox_pkg::N_PORTS],
  input  logic [mailbox_pkg::DATA_W-1:0]   sw_wdata_i   [mailbox_pkg::N_PORTS],
  input  logic [mailbox_pkg::STRB_W-1:0]   sw_wstrb_i   [mailbox_pkg::N_PORTS],
  input  mailbox_pkg::mailbox_tag_t        sw_tag_i     [mailbox_pkg::N_PORTS],
  output logic                             sw_bvalid_o  [mailbox_pkg::N_PORTS],
  input  logic                             sw_bready_i  [mailbox_pkg::N_PORTS],

  // Egress toward the switches and the HP endpoint
  output logic                             m_awvalid_o  [mailbox_pkg::N_PORTS],
  input  logic                             m_awready_i  [mailbox_pkg::N_PORTS],
  output logic [mailbox_pkg::ADDR_W-1:0]   m_awaddr_o   [mailbox_pkg::N_PORTS],
  output logic                             m_wvalid_o   [mailbox_pkg::N_PORTS],
  input  logic                             m_wready_i   [mailbox_pkg::N_PORTS],
  output logic [mailbox_pkg::DATA_W-1:0]   m_wdata_o    [mailbox_pkg::N_PORTS],
  output logic [mailbox_pkg::STRB_W-1:0]   m_wstrb_o    [mailbox_pkg::N_PORTS],
  output mailbox_pkg::mailbox_tag_t        m_tag_o      [mailbox_pkg::N_PORTS]
);

  logic                            req     [mailbox_pkg::N_PORTS];
  logic [mailbox_pkg::N_PORTS-1:0] tgt     [mailbox_pkg::N_PORTS];
  mailbox_pkg::flit_t              flit    [mailbox_pkg::N_PORTS];
  logic                            grant   [mailbox_pkg::N_PORTS];
  logic                            wr_en   [mailbox_pkg::N_PORTS];
  mailbox_pkg::flit_t              wr_flit [mailbox_pkg::N_PORTS];
  logic                            full    [mailbox_pkg::N_PORTS];

  for (genvar p = 0; p < mailbox_pkg::N_PORTS; p++) begin : g_port
    mailbox_ingress i_ingress (
      .clk       (clk),
      .rst_n     (rst_n),
      .awvalid_i (sw_awvalid_i[p]),
      .awready_o (sw_awready_o[p]),
      .awaddr_i  (sw_awaddr_i[p]),
      .wvalid_i  (sw_wvalid_i[p]),
      .wready_o  (sw_wready_o[p]),
      .wdata_i   (sw_wdata_i[p]),
      .wstrb_i   (sw_wstrb_i[p]),
      .tag_i     (sw_tag_i[p]),
      .bvalid_o  (sw_bvalid_o[p]),
      .bready_i  (sw_bready_i[p]),
      .req_o     (req[p]),
      .tgt_o     (tgt[p]),
      .flit_o    (flit[p]),
      .grant_i   (grant[p])
    );

    mailbox_egress_queue i_queue (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_en_i     (wr_en[p]),
      .wr_flit_i   (wr_flit[p]),
      .full_o      (full[p]),
      .m_awvalid_o (m_awvalid_o[p]),
      .m_awready_i (m_awready_i[p]),
      .m_awaddr_o  (m_awaddr_o[p]),
      .m_wvalid_o  (m_wvalid_o[p]),
      .m_wready_i  (m_wready_i[p]),
      .m_wdata_o   (m_wdata_o[p]),
      .m_wstrb_o   (m_wstrb_o[p]),
      .m_tag_o     (m_tag_o[p])
    );
  end

  mailbox_crossbar i_xbar (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (req),
    .tgt_i     (tgt),
    .flit_i    (flit),
    .full_i    (full),
    .grant_o   (grant),
    .wr_en_o   (wr_en),
    .wr_flit_o (wr_flit)
  );

endmodule

//--- tb_mailbox_center.sv
`timescale 1ns/1ps

module tb_mailbox_center;

  localparam int N       = mailbox_pkg::N_PORTS;
  localparam int TBL_MAX = 48;
  localparam int TIMEOUT = 100;
  localparam int NEVER   = 20;

  logic                           clk;
  logic                           rst_n;
  logic                           sw_awvalid [N];
  logic                           sw_awready [N];
  logic [mailbox_pkg::ADDR_W-1:0] sw_awaddr  [N];
  logic                           sw_wvalid  [N];
  logic                           sw_wready  [N];
  logic [mailbox_pkg::DATA_W-1:0] sw_wdata   [N];
  logic [mailbox_pkg::STRB_W-1:0] sw_wstrb   [N];
  mailbox_pkg::mailbox_tag_t      sw_tag     [N];
  logic                           sw_bvalid  [N];
  logic                           sw_bready  [N];
  logic                           m_awvalid  [N];
  logic                           m_awready  [N];
  logic [mailbox_pkg::ADDR_W-1:0] m_awaddr   [N];
  logic                           m_wvalid   [N];
  logic                           m_wready   [N];
  logic [mailbox_pkg::DATA_W-1:0] m_wdata    [N];
  logic [mailbox_pkg::STRB_W-1:0] m_wstrb    [N];
  mailbox_pkg::mailbox_tag_t      m_tag      [N];

  // Stimulus table, one row per write, rows of a group go out together
  int                             tbl_n;
  int                             tbl_src   [TBL_MAX];
  logic [mailbox_pkg::ADDR_W-1:0] tbl_addr  [TBL_MAX];
  logic [mailbox_pkg::DATA_W-1:0] tbl_data  [TBL_MAX];
  logic [mailbox_pkg::STRB_W-1:0] tbl_strb  [TBL_MAX];
  mailbox_pkg::mailbox_tag_t      tbl_tag   [TBL_MAX];
  logic [N-1:0]                   tbl_tgt   [TBL_MAX];
  int                             tbl_grp   [TBL_MAX];
  int                             tbl_hold  [TBL_MAX];
  logic [N-1:0]                   tbl_stall [TBL_MAX];

  mailbox_pkg::flit_t exp_q [N][$];
  logic [N-1:0]       stall;
  logic [N-1:0]       src_tgt  [N];
  int                 occ      [N];
  logic               prev_acc [N];
  logic               prev_bv  [N];
  logic               prev_br  [N];
  int                 err_value;
  int                 err_other;

  mailbox_center i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sw_awvalid_i (sw_awvalid),
    .sw_awready_o (sw_awready),
    .sw_awaddr_i  (sw_awaddr),
    .sw_wvalid_i  (sw_wvalid),
    .sw_wready_o  (sw_wready),
    .sw_wdata_i   (sw_wdata),
    .sw_wstrb_i   (sw_wstrb),
    .sw_tag_i     (sw_tag),
    .sw_bvalid_o  (sw_bvalid),
    .sw_bready_i  (sw_bready),
    .m_awvalid_o  (m_awvalid),
    .m_awready_i  (m_awready),
    .m_awaddr_o   (m_awaddr),
    .m_wvalid_o   (m_wvalid),
    .m_wready_i   (m_wready),
    .m_wdata_o    (m_wdata),
    .m_wstrb_o    (m_wstrb),
    .m_tag_o      (m_tag)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always_comb begin
    for (int o = 0; o < N; o++) begin
      m_awready[o] = !stall[o];
      m_wready[o]  = !stall[o];
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
      err_value++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    err_other++;
  endtask

  task automatic add_entry(input int src, input logic [7:0] cluster, input logic prio,
                           input logic [3:0] hops, input logic [N-1:0] tgt, input int grp,
                           input int hold = 0, input logic [N-1:0] stl = '0);
    tbl_src[tbl_n]   = src;
    tbl_addr[tbl_n]  = {cluster, 8'($urandom)};
    tbl_data[tbl_n]  = $urandom;
    tbl_strb[tbl_n]  = 4'($urandom);
    tbl_tag[tbl_n]   = '{prio: prio, eop: 1'($urandom), hops: hops, parity: 1'($urandom)};
    tbl_tgt[tbl_n]   = tgt;
    tbl_grp[tbl_n]   = grp;
    tbl_hold[tbl_n]  = hold;
    tbl_stall[tbl_n] = stl;
    tbl_n++;
  endtask

  // Expected egress flit, one hop added and parity resealed
  function automatic mailbox_pkg::flit_t expected_flit(input int e);
    mailbox_pkg::flit_t f;
    int                 ones;
    f.addr = tbl_addr[e];
    f.data = tbl_data[e];
    f.strb = tbl_strb[e];
    f.tag  = tbl_tag[e];
    if (f.tag.hops != 4'd15) begin
      f.tag.hops = f.tag.hops + 4'd1;
    end
    // Parity set for an odd count of ones over data and the covered tag bits
    ones = $countones(f.data) + $countones(f.tag.prio) + $countones(f.tag.eop)
           + $countones(f.tag.hops);
    f.tag.parity = ((ones % 2) == 1);
    return f;
  endfunction

  function automatic int queued();
    int n;
    n = 0;
    for (int o = 0; o < N; o++) begin
      n += exp_q[o].size();
    end
    return n;
  endfunction

  task automatic build_table();
    logic [7:0] code [N];
    code = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h00};
    // Every source to every cluster, rotated so no two rows share an output
    for (int k = 0; k < N; k++) begin
      for (int s = 0; s < N; s++) begin
        add_entry(s, code[(s + k) % N], 1'b0, 4'(s * 4 + k), 5'b1 << ((s + k) % N), k);
      end
    end
    add_entry(2, 8'hFF, 1'b0, 4'd6, 5'b11111, 5);
    add_entry(1, 8'h37, 1'b0, 4'd2, 5'b00000, 6);
    // Prio ahead of best-effort, then higher hops ahead
    add_entry(1, 8'h00, 1'b1, 4'd2, 5'b10000, 7);
    add_entry(0, 8'h00, 1'b0, 4'd9, 5'b10000, 7);
    add_entry(3, 8'h01, 1'b0, 4'd8, 5'b00001, 8);
    add_entry(2, 8'h01, 1'b0, 4'd3, 5'b00001, 8);
    // After LAT_LIMIT prio writes the waiting best-effort write goes
    add_entry(0, 8'h00, 1'b1, 4'd6, 5'b10000, 9);
    add_entry(1, 8'h00, 1'b1, 4'd5, 5'b10000, 9);
    add_entry(2, 8'h00, 1'b1, 4'd4, 5'b10000, 9);
    add_entry(4, 8'h00, 1'b0, 4'd10, 5'b10000, 9);
    add_entry(3, 8'h00, 1'b1, 4'd3, 5'b10000, 9);
    add_entry(4, 8'h03, 1'b0, 4'd0, 5'b00100, 10, 3);
    for (int s = 0; s < N; s++) begin
      add_entry(s, 8'h02, 1'b0, 4'(9 - 2 * s), 5'b00010, 11, 0, 5'b00010);
    end
  endtask

  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while (queued() > 0 && cyc < TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    assert (queued() == 0)
      else report_error($sformatf("%0d expected egress writes never appeared", queued()));
  endtask

  task automatic apply_group(input int first, input int last);
    bit  acc  [TBL_MAX];
    int  hold [TBL_MAX];
    int  cyc;
    int  idle;
    int  n_acc;
    int  pending;
    int  held;
    bit  stalled;
    bit  unknown;
    @(posedge clk);
    #1;
    stall   = tbl_stall[first];
    stalled = |tbl_stall[first];
    pending = 0;
    unknown = 1'b0;
    for (int e = first; e <= last; e++) begin
      acc[e]  = 1'b0;
      hold[e] = tbl_hold[e];
      for (int o = 0; o < N; o++) begin
        if (tbl_tgt[e][o]) exp_q[o].push_back(expected_flit(e));
      end
      if (tbl_tgt[e] == '0) unknown = 1'b1;
      else pending++;
      src_tgt[tbl_src[e]]    = tbl_tgt[e];
      sw_awvalid[tbl_src[e]] = 1'b1;
      sw_wvalid[tbl_src[e]]  = 1'b1;
      sw_awaddr[tbl_src[e]]  = tbl_addr[e];
      sw_wdata[tbl_src[e]]   = tbl_data[e];
      sw_wstrb[tbl_src[e]]   = tbl_strb[e];
      sw_tag[tbl_src[e]]     = tbl_tag[e];
      sw_bready[tbl_src[e]]  = (tbl_hold[e] == 0);
    end
    cyc   = 0;
    idle  = 0;
    n_acc = 0;
    held  = 0;
    while ((pending > 0 || held > 0 || (unknown && cyc < NEVER)) && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
      idle++;
      for (int e = first; e <= last; e++) begin
        if (!acc[e] && sw_awready[tbl_src[e]]) begin
          acc[e] = 1'b1;
          idle   = 0;
          n_acc++;
          assert (tbl_tgt[e] != '0)
            else report_error($sformatf("unknown cluster accepted from source %0d", tbl_src[e]));
          if (tbl_tgt[e] != '0) pending--;
        end
      end
      // A stalled egress takes exactly FIFO_DEPTH writes
      if (stalled && idle > 8) begin
        check_value("writes accepted into stalled egress", n_acc, mailbox_pkg::FIFO_DEPTH);
        stalled = 1'b0;
      end
      @(posedge clk);
      #1;
      if (!stalled) stall = '0;
      held = 0;
      for (int e = first; e <= last; e++) begin
        if (acc[e] && hold[e] > 0) begin
          hold[e]--;
          held++;
        end else if (acc[e]) begin
          sw_awvalid[tbl_src[e]] = 1'b0;
          sw_wvalid[tbl_src[e]]  = 1'b0;
          sw_bready[tbl_src[e]]  = 1'b1;
        end
      end
    end
    assert (pending == 0)
      else report_error($sformatf("group %0d timed out, %0d writes not accepted",
                                  tbl_grp[first], pending));
    for (int e = first; e <= last; e++) begin
      sw_awvalid[tbl_src[e]] = 1'b0;
      sw_wvalid[tbl_src[e]]  = 1'b0;
      sw_bready[tbl_src[e]]  = 1'b1;
    end
    stall = '0;
    wait_drain();
  endtask

  task automatic pop_egress(input int o);
    mailbox_pkg::flit_t exp;
    assert (exp_q[o].size() > 0)
      else report_error($sformatf("unexpected write on egress %0d", o));
    if (exp_q[o].size() > 0) begin
      exp = exp_q[o].pop_front();
      check_value($sformatf("m_awaddr_o[%0d]", o), 64'(m_awaddr[o]), 64'(exp.addr));
      check_value($sformatf("m_wdata_o[%0d]", o), 64'(m_wdata[o]), 64'(exp.data));
      check_value($sformatf("m_wstrb_o[%0d]", o), 64'(m_wstrb[o]), 64'(exp.strb));
      check_value($sformatf("m_tag_o[%0d]", o), 64'(m_tag[o]), 64'(exp.tag));
    end
  endtask

  // Egress models
  // Queue occupancy model, a write shows as valid one cycle after acceptance
  always @(negedge clk) begin
    if (!rst_n) begin
      for (int o = 0; o < N; o++) begin
        occ[o] = 0;
      end
    end else begin
      for (int o = 0; o < N; o++) begin
        check_value($sformatf("m_awvalid_o[%0d]", o), m_awvalid[o], occ[o] > 0);
        check_value($sformatf("m_wvalid_o[%0d]", o), m_wvalid[o], occ[o] > 0);
        if (occ[o] > 0 && m_awready[o] && m_wready[o]) begin
          pop_egress(o);
          occ[o]--;
        end
        for (int s = 0; s < N; s++) begin
          if (sw_awready[s] && src_tgt[s][o]) occ[o]++;
        end
      end
    end
  end

  // bvalid one cycle after acceptance, held until bready
  always @(negedge clk) begin
    for (int s = 0; s < N; s++) begin
      if (!rst_n) begin
        prev_acc[s] = 1'b0;
        prev_bv[s]  = 1'b0;
        prev_br[s]  = 1'b1;
      end else begin
        check_value($sformatf("sw_bvalid_o[%0d]", s), sw_bvalid[s],
                    prev_acc[s] || (prev_bv[s] && !prev_br[s]));
        check_value($sformatf("sw_wready_o[%0d]", s), sw_wready[s], sw_awready[s]);
        assert (!(sw_bvalid[s] && sw_awready[s]))
          else report_error($sformatf("source %0d accepted with a response pending", s));
        prev_acc[s] = sw_awready[s];
        prev_bv[s]  = sw_bvalid[s];
        prev_br[s]  = sw_bready[s];
      end
    end
  end

  initial begin
    int first;
    void'($urandom(32'h5a65_cb08));
    err_value = 0;
    err_other = 0;
    tbl_n     = 0;
    stall     = '0;
    rst_n     = 1'b0;
    for (int s = 0; s < N; s++) begin
      src_tgt[s]    = '0;
      sw_awvalid[s] = 1'b0;
      sw_wvalid[s]  = 1'b0;
      sw_awaddr[s]  = '0;
      sw_wdata[s]   = '0;
      sw_wstrb[s]   = '0;
      sw_tag[s]     = '0;
      sw_bready[s]  = 1'b1;
    end
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    first = 0;
    for (int e = 0; e < tbl_n; e++) begin
      if (e == tbl_n - 1 || tbl_grp[e + 1] != tbl_grp[e]) begin
        apply_group(first, e);
        first = e + 1;
      end
    end
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
mailbox_pkg.sv
mailbox_ingress.sv
mailbox_out_arbiter.sv
mailbox_crossbar.sv
mailbox_egress_queue.sv
mailbox_center.sv
tb_mailbox_center.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mailbox_center -Mdir obj_dir -o sim_mailbox -f all.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_mailbox > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished cleanly"
exit 0
